// ==== Bender.yml ====
package:
  name: ctr_feistel_encrypt

sources:
  - files:
      - hdl/feistel_pkg.sv
      - hdl/ctr_pkg.sv
      - hdl/key_schedule.sv
      - hdl/feistel_round.sv
      - hdl/ctr_block_feed.sv
      - hdl/ctr_keystream_xor.sv
      - hdl/ctr_feistel_encrypt.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_ctr_feistel_encrypt.sv

// ==== ctr_feistel_encrypt.f ====
hdl/feistel_pkg.sv
hdl/ctr_pkg.sv
hdl/key_schedule.sv
hdl/feistel_round.sv
hdl/ctr_block_feed.sv
hdl/ctr_keystream_xor.sv
hdl/ctr_feistel_encrypt.sv
testbench/tb_clock_gen.sv
testbench/tb_ctr_feistel_encrypt.sv

// ==== hdl/ctr_block_feed.sv ====
`timescale 1ns/1ns

module ctr_block_feed (
	input logic clk,
	input logic reset_n,
	input logic key_valid,
	input logic tvalid,
	input logic [feistel_pkg::block_width-1:0] plaintext,
	input logic [feistel_pkg::block_width-1:0] iv,
	output logic blk_valid,
	output logic [feistel_pkg::block_width-1:0] blk_data,
	output logic pt_valid,
	output logic [feistel_pkg::block_width-1:0] pt_data
);
	import feistel_pkg::*;
	import ctr_pkg::*;

	logic accept;
	logic first_block;
	logic [block_width-1:0] counter;

	// Blocks without a ready key are dropped.
	assign accept = tvalid & key_valid;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			blk_valid <= 1'b0;
			pt_valid <= 1'b0;
			first_block <= 1'b1;
			counter <= '0;
		end else begin
			blk_valid <= accept;
			pt_valid <= accept;
			if (accept) begin
				counter <= first_block ? iv : counter + ctr_step;
				first_block <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pt_data <= plaintext;
		end
	end

	assign blk_data = counter;

endmodule

// ==== hdl/ctr_feistel_encrypt.sv ====
`timescale 1ns/1ns

module ctr_feistel_encrypt (
	input logic clk,
	input logic reset_n,
	input logic sbox_valid,
	input logic [feistel_pkg::sbox_width-1:0] sbox_out,
	input logic key_tvalid,
	input logic [feistel_pkg::key_width-1:0] key,
	input logic tvalid,
	input logic [feistel_pkg::block_width-1:0] plaintext,
	input logic [feistel_pkg::block_width-1:0] iv,
	output logic valid,
	output logic [feistel_pkg::block_width-1:0] ciphertext
);
	import feistel_pkg::*;

	logic key_valid;
	logic [half_width-1:0] round_keys [num_rounds];

	// Entry 0 is the counter block, entry num_rounds the keystream.
	logic [num_rounds:0] stage_valid;
	logic [block_width-1:0] stage_data [num_rounds+1];

	logic pt_valid;
	logic [block_width-1:0] pt_data;

	key_schedule i_key_schedule (
		.clk(clk),
		.reset_n(reset_n),
		.key_tvalid(key_tvalid),
		.key(key),
		.key_valid(key_valid),
		.round_keys(round_keys)
	);

	ctr_block_feed i_block_feed (
		.clk(clk),
		.reset_n(reset_n),
		.key_valid(key_valid),
		.tvalid(tvalid),
		.plaintext(plaintext),
		.iv(iv),
		.blk_valid(stage_valid[0]),
		.blk_data(stage_data[0]),
		.pt_valid(pt_valid),
		.pt_data(pt_data)
	);

	for (genvar r = 0; r < num_rounds; r++) begin : g_round
		feistel_round i_round (
			.clk(clk),
			.reset_n(reset_n),
			.sbox_valid(sbox_valid),
			.sbox_out(sbox_out),
			.round_key(round_keys[r]),
			.in_valid(stage_valid[r]),
			.in_data(stage_data[r]),
			.out_valid(stage_valid[r+1]),
			.out_data(stage_data[r+1])
		);
	end

	ctr_keystream_xor i_keystream_xor (
		.clk(clk),
		.reset_n(reset_n),
		.pt_valid(pt_valid),
		.pt_data(pt_data),
		.ks_valid(stage_valid[num_rounds]),
		.ks_data(stage_data[num_rounds]),
		.valid(valid),
		.ciphertext(ciphertext)
	);

endmodule

// ==== hdl/ctr_keystream_xor.sv ====
`timescale 1ns/1ns

module ctr_keystream_xor (
	input logic clk,
	input logic reset_n,
	input logic pt_valid,
	input logic [feistel_pkg::block_width-1:0] pt_data,
	input logic ks_valid,
	input logic [feistel_pkg::block_width-1:0] ks_data,
	output logic valid,
	output logic [feistel_pkg::block_width-1:0] ciphertext
);
	import feistel_pkg::*;
	import ctr_pkg::*;

	logic [block_width-1:0] pt_dly [cipher_lat];
	logic [cipher_lat-1:0] pv_dly;

	// Plaintext rides alongside the round chain.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			pv_dly <= '0;
		end else begin
			pv_dly <= {pv_dly[cipher_lat-2:0], pt_valid};
		end
	end

	always_ff @(posedge clk) begin
		pt_dly[0] <= pt_data;
		for (int i = 1; i < cipher_lat; i++) begin
			pt_dly[i] <= pt_dly[i-1];
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			valid <= 1'b0;
		end else begin
			valid <= ks_valid & pv_dly[cipher_lat-1];
		end
	end

	always_ff @(posedge clk) begin
		if (ks_valid) begin
			ciphertext <= pt_dly[cipher_lat-1] ^ ks_data;
		end
	end

endmodule

// ==== hdl/ctr_pkg.sv ====
package ctr_pkg;

	// Latency of the complete round chain.
	localparam int cipher_lat = feistel_pkg::num_rounds * feistel_pkg::round_lat;

	// Block feed register, round chain, output register.
	localparam int ctr_lat = cipher_lat + 2;

	// Counter increment between blocks.
	localparam logic [feistel_pkg::block_width-1:0] ctr_step = 1;

endpackage

// ==== hdl/feistel_pkg.sv ====
package feistel_pkg;

	// Block geometry.
	localparam int block_width = 64;
	localparam int half_width = block_width / 2;

	// Cipher key.
	localparam int key_width = 128;

	// Round structure.
	localparam int num_rounds = 5;
	localparam int round_lat = 3;

	// S-box table, one byte per entry.
	localparam int sbox_depth = 256;
	localparam int sbox_width = 8;

	// Left rotation applied to the key between round keys.
	localparam int key_rot = 24;

	// Key schedule FSM.
	typedef enum logic [1:0] {
		idle,
		expand,
		ready
	} key_state_t;

endpackage

// ==== hdl/feistel_round.sv ====
`timescale 1ns/1ns

module feistel_round (
	input logic clk,
	input logic reset_n,
	input logic sbox_valid,
	input logic [feistel_pkg::sbox_width-1:0] sbox_out,
	input logic [feistel_pkg::half_width-1:0] round_key,
	input logic in_valid,
	input logic [feistel_pkg::block_width-1:0] in_data,
	output logic out_valid,
	output logic [feistel_pkg::block_width-1:0] out_data
);
	import feistel_pkg::*;

	logic [sbox_width-1:0] sbox [sbox_depth];
	logic [$clog2(sbox_depth)-1:0] wr_addr;

	logic s1_valid;
	logic [half_width-1:0] s1_l;
	logic [half_width-1:0] s1_r;
	logic [half_width-1:0] s1_x;

	logic s2_valid;
	logic [half_width-1:0] s2_l;
	logic [half_width-1:0] s2_r;
	logic [half_width-1:0] s2_sub;

	// Local S-box copy filled from the broadcast byte stream.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wr_addr <= '0;
		end else if (sbox_valid) begin
			wr_addr <= wr_addr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (sbox_valid) begin
			sbox[wr_addr] <= sbox_out;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid;
			s2_valid <= s1_valid;
			out_valid <= s2_valid;
		end
	end

	// Stage 1, key mixing.
	always_ff @(posedge clk) begin
		s1_l <= in_data[block_width-1:half_width];
		s1_r <= in_data[half_width-1:0];
		s1_x <= in_data[half_width-1:0] ^ round_key;
	end

	// Stage 2, byte substitution.
	always_ff @(posedge clk) begin
		for (int b = 0; b < half_width / sbox_width; b++) begin
			s2_sub[b*sbox_width +: sbox_width] <= sbox[s1_x[b*sbox_width +: sbox_width]];
		end
		s2_l <= s1_l;
		s2_r <= s1_r;
	end

	// Stage 3, rotate by one byte, mix into L and swap.
	always_ff @(posedge clk) begin
		out_data <= {s2_r,
			s2_l ^ {s2_sub[half_width-sbox_width-1:0],
				s2_sub[half_width-1:half_width-sbox_width]}};
	end

endmodule

// ==== hdl/key_schedule.sv ====
`timescale 1ns/1ns

module key_schedule (
	input logic clk,
	input logic reset_n,
	input logic key_tvalid,
	input logic [feistel_pkg::key_width-1:0] key,
	output logic key_valid,
	output logic [feistel_pkg::half_width-1:0] round_keys [feistel_pkg::num_rounds]
);
	import feistel_pkg::*;

	key_state_t state;
	logic [key_width-1:0] key_rotated;
	logic [2:0] key_idx;

	function automatic logic [key_width-1:0] rotl_key(input logic [key_width-1:0] k);
		return {k[key_width-key_rot-1:0], k[key_width-1:key_width-key_rot]};
	endfunction

	// A new key restarts expansion from any state.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= idle;
			key_idx <= 3'd0;
		end else if (key_tvalid) begin
			state <= expand;
			key_idx <= 3'd1;
		end else if (state == expand) begin
			key_idx <= key_idx + 3'd1;
			if (int'(key_idx) == num_rounds - 1) begin
				state <= ready;
			end
		end
	end

	// Round key 0 is written straight from the key input.
	always_ff @(posedge clk) begin
		if (key_tvalid) begin
			key_rotated <= rotl_key(key);
			round_keys[0] <= key[half_width-1:0];
		end else if (state == expand) begin
			key_rotated <= rotl_key(key_rotated);
			round_keys[key_idx] <= key_rotated[half_width-1:0];
		end
	end

	assign key_valid = (state == ready);

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk,
	output logic reset_n
);
	localparam int half_period = 10;
	localparam int reset_cycles = 4;
	localparam int release_delay = 2;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// Reset is released just after the fourth rising edge.
	initial begin
		reset_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#release_delay reset_n = 1'b1;
	end

endmodule

// ==== testbench/tb_ctr_feistel_encrypt.sv ====
`timescale 1ns/1ns

module tb_ctr_feistel_encrypt;
	import feistel_pkg::*;
	import ctr_pkg::*;

	localparam int drive_delay = 2;
	localparam int key_wait = 8;
	localparam int reset_cycles = 4;
	localparam int idle_check_cycles = 24;
	localparam int burst_len = 20;
	localparam int gap_blocks = 10;
	localparam int max_gap = 7;
	localparam int key_blocks = 8;
	localparam int sbox_blocks = 8;
	localparam int drain_cycles = ctr_lat + 4;
	localparam int stim_cycles = reset_cycles + idle_check_cycles + 2 * (sbox_depth + 1)
		+ 2 * (key_wait + 1) + 1 + burst_len + gap_blocks * (max_gap + 1)
		+ 2 * key_blocks + sbox_blocks + 6 * drain_cycles;
	localparam int timeout_cycles = stim_cycles + ctr_lat + 50;

	logic clk;
	logic reset_n;
	logic sbox_valid;
	logic [sbox_width-1:0] sbox_out;
	logic key_tvalid;
	logic [key_width-1:0] key;
	logic tvalid;
	logic [block_width-1:0] plaintext;
	logic [block_width-1:0] iv;
	logic valid;
	logic [block_width-1:0] ciphertext;

	int cycle = 0;
	int mismatch_errors = 0;
	int pulse_errors = 0;
	logic [31:0] lfsr_state;

	// Reference model state.
	logic [sbox_width-1:0] model_sbox [sbox_depth];
	logic [half_width-1:0] model_rk [num_rounds];
	logic [block_width-1:0] model_counter;
	logic model_first;
	logic key_ready;

	// Expected outputs tagged with the cycle in which valid is due.
	int exp_due [$];
	logic [block_width-1:0] exp_data [$];
	logic due_now = 1'b0;
	logic [block_width-1:0] due_data;

	tb_clock_gen i_clock_gen (
		.clk(clk),
		.reset_n(reset_n)
	);

	ctr_feistel_encrypt i_dut (
		.clk(clk),
		.reset_n(reset_n),
		.sbox_valid(sbox_valid),
		.sbox_out(sbox_out),
		.key_tvalid(key_tvalid),
		.key(key),
		.tvalid(tvalid),
		.plaintext(plaintext),
		.iv(iv),
		.valid(valid),
		.ciphertext(ciphertext)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output logic [127:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[126:0], lfsr_state[0]};
		end
	endtask

	function automatic logic [half_width-1:0] round_key_of(input logic [key_width-1:0] k,
		input int idx);
		logic [key_width-1:0] rot;
		rot = k;
		for (int s = 0; s < key_rot * idx; s++) begin
			rot = {rot[key_width-2:0], rot[key_width-1]};
		end
		return rot[half_width-1:0];
	endfunction

	function automatic logic [half_width-1:0] round_f(input logic [half_width-1:0] r,
		input logic [half_width-1:0] k);
		logic [half_width-1:0] x;
		logic [half_width-1:0] sub;
		x = r ^ k;
		for (int b = 0; b < 4; b++) begin
			sub[b*8 +: 8] = model_sbox[x[b*8 +: 8]];
		end
		return {sub[23:0], sub[31:24]};
	endfunction

	// Halves stay unswapped after the last round.
	function automatic logic [block_width-1:0] encipher(input logic [block_width-1:0] blk);
		logic [half_width-1:0] l;
		logic [half_width-1:0] r;
		logic [half_width-1:0] t;
		l = blk[block_width-1:half_width];
		r = blk[half_width-1:0];
		for (int i = 0; i < num_rounds; i++) begin
			t = l ^ round_f(r, model_rk[i]);
			l = r;
			r = t;
		end
		return {l, r};
	endfunction

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			#drive_delay;
			tvalid = 1'b0;
			key_tvalid = 1'b0;
			sbox_valid = 1'b0;
		end
	endtask

	task automatic load_sbox();
		logic [127:0] bits;
		for (int a = 0; a < sbox_depth; a++) begin
			random_bits(sbox_width, bits);
			@(posedge clk);
			#drive_delay;
			sbox_valid = 1'b1;
			sbox_out = bits[sbox_width-1:0];
			model_sbox[a] = bits[sbox_width-1:0];
		end
		idle_cycles(1);
	endtask

	task automatic load_key();
		logic [127:0] bits;
		random_bits(key_width, bits);
		@(posedge clk);
		#drive_delay;
		key_tvalid = 1'b1;
		key = bits;
		key_ready = 1'b0;
		for (int i = 0; i < num_rounds; i++) begin
			model_rk[i] = round_key_of(bits, i);
		end
		idle_cycles(key_wait);
		key_ready = 1'b1;
	endtask

	// Leaves tvalid high; the caller ends the block with idle cycles.
	task automatic send_block();
		logic [127:0] pt_bits;
		logic [127:0] iv_bits;
		random_bits(block_width, pt_bits);
		random_bits(block_width, iv_bits);
		@(posedge clk);
		#drive_delay;
		tvalid = 1'b1;
		plaintext = pt_bits[block_width-1:0];
		iv = iv_bits[block_width-1:0];
		if (key_ready) begin
			if (model_first) begin
				model_counter = iv;
			end else begin
				model_counter = model_counter + 64'd1;
			end
			model_first = 1'b0;
			exp_due.push_back(cycle + ctr_lat);
			exp_data.push_back(plaintext ^ encipher(model_counter));
		end
	endtask

	task automatic wait_drain();
		idle_cycles(1);
		while (exp_due.size() != 0) begin
			idle_cycles(1);
		end
		idle_cycles(2);
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// Head of the queue is presented half a cycle before the edge that checks it.
	always @(negedge clk) begin
		if (exp_due.size() != 0 && exp_due[0] == cycle) begin
			due_now = 1'b1;
			due_data = exp_data[0];
			void'(exp_due.pop_front());
			void'(exp_data.pop_front());
		end else begin
			due_now = 1'b0;
		end
	end

	a_no_extra_valid: assert property (@(posedge clk) disable iff (!reset_n) valid |-> due_now)
		else begin
			pulse_errors++;
			$display("Time %0t: valid pulsed although no block was due", $time);
		end

	a_no_missing_valid: assert property (@(posedge clk) disable iff (!reset_n) due_now |-> valid)
		else begin
			pulse_errors++;
			$display("Time %0t: an expected valid pulse did not arrive", $time);
		end

	a_ciphertext: assert property (@(posedge clk) disable iff (!reset_n)
		(valid && due_now) |-> (ciphertext == due_data))
		else begin
			mismatch_errors++;
			$display("MISMATCH time %0t signal ciphertext expected %h actual %h",
				$time, $sampled(due_data), $sampled(ciphertext));
		end

	always @(posedge clk) begin
		if (cycle >= timeout_cycles) begin
			$display("Timeout after %0d cycles, the test sequence did not complete", cycle);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial begin
		logic [127:0] gap;
		sbox_valid = 1'b0;
		sbox_out = '0;
		key_tvalid = 1'b0;
		key = '0;
		tvalid = 1'b0;
		plaintext = '0;
		iv = '0;
		lfsr_state = 32'h9413cafb;
		key_ready = 1'b0;
		model_first = 1'b1;
		model_counter = '0;
		wait (reset_n === 1'b1);

		// Blocks without a key must vanish.
		idle_cycles(4);
		repeat (3) begin
			send_block();
			idle_cycles(5);
		end
		wait_drain();

		load_sbox();
		load_key();

		// Single block whose counter comes from iv.
		send_block();
		wait_drain();

		repeat (burst_len) send_block();
		wait_drain();

		repeat (gap_blocks) begin
			send_block();
			random_bits(3, gap);
			idle_cycles(gap[2:0]);
		end
		wait_drain();

		// Counter carries on across the key change.
		load_key();
		repeat (key_blocks) begin
			send_block();
			idle_cycles(1);
		end
		wait_drain();

		load_sbox();
		repeat (sbox_blocks) send_block();
		wait_drain();

		$display("Error counts: %0d ciphertext mismatches, %0d valid pulse errors",
			mismatch_errors, pulse_errors);
		if (mismatch_errors + pulse_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
